// File: rtl/mem_map_pkg.sv
// Memory map constants
package mem_map_pkg;

   // ---------------------------------------------------------------------------
   // port widths
   // ---------------------------------------------------------------------------
   localparam int mcr_addr_bits  = 14;
   localparam int mcr_word_bits  = 49;
   localparam int dram_addr_bits = 22;
   localparam int vram_addr_bits = 15;
   localparam int data_bits      = 32;

   // cycles from transaction start to ready/done pulse
   localparam int dram_latency = 5;

   // ---------------------------------------------------------------------------
   // default array depths in words
   // ---------------------------------------------------------------------------
   localparam int mcr_depth_default  = 16384;
   localparam int dram_depth_default = 262144;
   // 672 x 1024 pixels at one bit each
   localparam int vram_depth_default = 21504;

endpackage

// File: rtl/mem_bus_pkg.sv
// Memory port bundles
package mem_bus_pkg;

   // ---------------------------------------------------------------------------
   // microcode RAM
   // ---------------------------------------------------------------------------
   typedef struct packed {
      logic [mem_map_pkg::mcr_addr_bits-1:0] addr;
      logic [mem_map_pkg::mcr_word_bits-1:0] wdata;
      // write strobe
      logic                                  write;
      // load the prefetch register
      logic                                  prefetch;
   } mcr_req_t;

   // ---------------------------------------------------------------------------
   // main memory
   // ---------------------------------------------------------------------------
   typedef struct packed {
      logic [mem_map_pkg::dram_addr_bits-1:0] addr;
      logic [mem_map_pkg::data_bits-1:0]      wdata;
      // request levels, held until ready or done
      logic                                   read;
      logic                                   write;
   } dram_req_t;

   typedef struct packed {
      logic [mem_map_pkg::data_bits-1:0] rdata;
      logic                              ready;
      logic                              done;
   } dram_resp_t;

   // ---------------------------------------------------------------------------
   // video RAM, CPU side
   // ---------------------------------------------------------------------------
   typedef struct packed {
      logic [mem_map_pkg::vram_addr_bits-1:0] addr;
      logic [mem_map_pkg::data_bits-1:0]      wdata;
      logic                                   read;
      logic                                   write;
   } vram_cpu_req_t;

   typedef struct packed {
      logic [mem_map_pkg::data_bits-1:0] rdata;
      logic                              ready;
      logic                              done;
   } vram_cpu_resp_t;

endpackage

// File: rtl/mem_slot_control.sv
// Memory slot control
`timescale 1ns/1ps

module mem_slot_control
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fetch,
   input  logic                   mcr_write,
   input  mem_bus_pkg::dram_req_t dram_req,
   input  logic                   vram_pending,
   output logic                   mcr_done,
   output logic                   dram_start_write,
   output logic                   dram_ready,
   output logic                   dram_done,
   output logic                   vram_commit
);

   localparam int last_stage = mem_map_pkg::dram_latency - 1;

   logic [mem_map_pkg::dram_latency-1:0] ack_line;
   logic                                 dram_start;
   logic                                 was_write;

   // microcode write finishes one cycle after the strobe
   always_ff @(posedge clk)
   begin
      if (reset)
         mcr_done <= 1'b0;
      else
         mcr_done <= mcr_write;
   end

   // ---------------------------------------------------------------------------
   // main memory delay line
   // ---------------------------------------------------------------------------
   // only one transaction in flight; requests seen while busy are dropped
   assign dram_start       = (ack_line == '0) && (dram_req.read || dram_req.write);
   assign dram_start_write = dram_start && dram_req.write;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_line  <= '0;
         was_write <= 1'b0;
      end
      else
      begin
         ack_line <= {ack_line[last_stage-1:0], dram_start};
         // write wins when both levels are up
         if (dram_start)
            was_write <= dram_req.write;
      end
   end

   assign dram_done  = ack_line[last_stage] && was_write;
   assign dram_ready = ack_line[last_stage] && !was_write;

   // video write may only use a cycle free of fetch and microcode write
   assign vram_commit = vram_pending && !fetch && !mcr_done;

endmodule

// File: rtl/mcr_ram.sv
// Microcode RAM
`timescale 1ns/1ps

module mcr_ram
#(
   parameter int MCR_DEPTH = 16384
)
(
   input  logic                                  clk,
   input  logic                                  reset,
   input  mem_bus_pkg::mcr_req_t                 req,
   output logic [mem_map_pkg::mcr_word_bits-1:0] rdata
);

   logic [mem_map_pkg::mcr_word_bits-1:0] mem [0:MCR_DEPTH-1];

   // contents come up cleared
   initial
   begin
      for (int i = 0; i < MCR_DEPTH; i++)
         mem[i] = '0;
   end

   // write on the strobe edge
   always_ff @(posedge clk)
   begin
      if (req.write)
         mem[req.addr] <= req.wdata;
   end

   // prefetch register, same-address write returns the old word
   always_ff @(posedge clk)
   begin
      if (reset)
         rdata <= '0;
      else if (req.prefetch)
         rdata <= mem[req.addr];
   end

endmodule

// File: rtl/dram_store.sv
// Main memory array
`timescale 1ns/1ps

module dram_store
#(
   parameter int DRAM_DEPTH = 262144
)
(
   input  logic                                   clk,
   input  logic [mem_map_pkg::dram_addr_bits-1:0] addr,
   input  logic [mem_map_pkg::data_bits-1:0]      wdata,
   input  logic                                   start_write,
   output logic [mem_map_pkg::data_bits-1:0]      rdata
);

   localparam int idx_bits = $clog2(DRAM_DEPTH);

   logic [mem_map_pkg::data_bits-1:0] mem [0:DRAM_DEPTH-1];
   logic [idx_bits-1:0]               idx;
   logic                              in_range;

   initial
   begin
      for (int i = 0; i < DRAM_DEPTH; i++)
         mem[i] = '0;
   end

   // ---------------------------------------------------------------------------
   // range check
   // ---------------------------------------------------------------------------
   // only the implemented part of the address space is backed
   assign in_range = ({10'd0, addr} < DRAM_DEPTH);
   assign idx      = addr[idx_bits-1:0];

   always_ff @(posedge clk)
   begin
      if (start_write && in_range)
         mem[idx] <= wdata;
   end

   // unbacked words float high
   assign rdata = in_range ? mem[idx] : '1;

endmodule

// File: rtl/vram_store.sv
// Video RAM with pending write
`timescale 1ns/1ps

module vram_store
#(
   parameter int VRAM_DEPTH = 21504
)
(
   input  logic                                   clk,
   input  logic                                   reset,
   input  mem_bus_pkg::vram_cpu_req_t             cpu_req,
   input  logic                                   commit,
   input  logic [mem_map_pkg::vram_addr_bits-1:0] disp_addr,
   output mem_bus_pkg::vram_cpu_resp_t            cpu_resp,
   output logic                                   pending,
   output logic [mem_map_pkg::data_bits-1:0]      disp_rdata
);

   logic [mem_map_pkg::data_bits-1:0]      mem [0:VRAM_DEPTH-1];
   logic [mem_map_pkg::vram_addr_bits-1:0] pend_addr;
   logic [mem_map_pkg::data_bits-1:0]      pend_data;
   logic                                   read_ack;
   logic                                   write_ack;

   initial
   begin
      for (int i = 0; i < VRAM_DEPTH; i++)
         mem[i] = '0;
   end

   // ---------------------------------------------------------------------------
   // pending write buffer
   // ---------------------------------------------------------------------------
   // payload only, the flag says whether it is live
   always_ff @(posedge clk)
   begin
      if (cpu_req.write)
      begin
         pend_addr <= cpu_req.addr;
         pend_data <= cpu_req.wdata;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pending   <= 1'b0;
         read_ack  <= 1'b0;
         write_ack <= 1'b0;
      end
      else
      begin
         // a fresh strobe keeps the buffer live even on a commit edge
         if (cpu_req.write)
            pending <= 1'b1;
         else if (commit)
            pending <= 1'b0;
         read_ack  <= cpu_req.read;
         write_ack <= commit;
      end
   end

   always_ff @(posedge clk)
   begin
      if (commit)
         mem[pend_addr] <= pend_data;
   end

   // ---------------------------------------------------------------------------
   // read ports
   // ---------------------------------------------------------------------------
   always_comb
   begin
      cpu_resp.rdata = mem[cpu_req.addr];
      cpu_resp.ready = read_ack;
      cpu_resp.done  = write_ack;
   end

   assign disp_rdata = mem[disp_addr];

endmodule

// File: rtl/debug_ram_controller.sv
// Debug memory controller
`timescale 1ns/1ps

module debug_ram_controller
#(
   parameter int MCR_DEPTH  = mem_map_pkg::mcr_depth_default,
   parameter int DRAM_DEPTH = mem_map_pkg::dram_depth_default,
   parameter int VRAM_DEPTH = mem_map_pkg::vram_depth_default
)
(
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic                                   fetch,
   input  mem_bus_pkg::mcr_req_t                  mcr_req,
   input  mem_bus_pkg::dram_req_t                 dram_req,
   input  mem_bus_pkg::vram_cpu_req_t             vram_cpu_req,
   input  logic [mem_map_pkg::vram_addr_bits-1:0] vram_disp_addr,
   output logic [mem_map_pkg::mcr_word_bits-1:0]  mcr_rdata,
   output logic                                   mcr_done,
   output mem_bus_pkg::dram_resp_t                dram_resp,
   output mem_bus_pkg::vram_cpu_resp_t            vram_cpu_resp,
   output logic [mem_map_pkg::data_bits-1:0]      vram_disp_rdata
);

   logic                              dram_start_write;
   logic                              dram_ready;
   logic                              dram_done;
   logic [mem_map_pkg::data_bits-1:0] dram_rdata;
   logic                              vram_commit;
   logic                              vram_pending;

   // ---------------------------------------------------------------------------
   // slot control
   // ---------------------------------------------------------------------------
   mem_slot_control mem_slot_control_inst
   (
      .clk              (clk),
      .reset            (reset),
      .fetch            (fetch),
      .mcr_write        (mcr_req.write),
      .dram_req         (dram_req),
      .vram_pending     (vram_pending),
      .mcr_done         (mcr_done),
      .dram_start_write (dram_start_write),
      .dram_ready       (dram_ready),
      .dram_done        (dram_done),
      .vram_commit      (vram_commit)
   );

   // ---------------------------------------------------------------------------
   // storage
   // ---------------------------------------------------------------------------
   mcr_ram #(.MCR_DEPTH(MCR_DEPTH)) mcr_ram_inst
   (
      .clk   (clk),
      .reset (reset),
      .req   (mcr_req),
      .rdata (mcr_rdata)
   );

   dram_store #(.DRAM_DEPTH(DRAM_DEPTH)) dram_store_inst
   (
      .clk         (clk),
      .addr        (dram_req.addr),
      .wdata       (dram_req.wdata),
      .start_write (dram_start_write),
      .rdata       (dram_rdata)
   );

   vram_store #(.VRAM_DEPTH(VRAM_DEPTH)) vram_store_inst
   (
      .clk        (clk),
      .reset      (reset),
      .cpu_req    (vram_cpu_req),
      .commit     (vram_commit),
      .disp_addr  (vram_disp_addr),
      .cpu_resp   (vram_cpu_resp),
      .pending    (vram_pending),
      .disp_rdata (vram_disp_rdata)
   );

   // main memory response, data from the array, pulses from control
   always_comb
   begin
      dram_resp.rdata = dram_rdata;
      dram_resp.ready = dram_ready;
      dram_resp.done  = dram_done;
   end

endmodule

// File: bench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic reset
);

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   // reset held for 8 cycles, released just after an edge
   initial
   begin
      reset = 1'b1;
      repeat (8)
         @(posedge clk);
      #1;
      reset = 1'b0;
   end

endmodule

// File: bench/debug_ram_controller_properties.sv
// Slot control assertions
`timescale 1ns/1ps

module debug_ram_controller_properties
(
   input logic clk,
   input logic reset,
   input logic fetch,
   input logic mcr_write,
   input logic vram_pending,
   input logic vram_commit,
   input logic dram_ready,
   input logic dram_done
);

   // main memory pulses never overlap
   no_ready_and_done: assert property (@(posedge clk) disable iff (reset)
      !(dram_ready && dram_done))
      else $error("dram ready and done high in the same cycle");

   ready_one_cycle: assert property (@(posedge clk) disable iff (reset)
      dram_ready |=> !dram_ready)
      else $error("dram ready held longer than one cycle");

   done_one_cycle: assert property (@(posedge clk) disable iff (reset)
      dram_done |=> !dram_done)
      else $error("dram done held longer than one cycle");

   // no commit in a fetch cycle or in the cycle after a microcode write strobe
   commit_slot_free: assert property (@(posedge clk) disable iff (reset)
      vram_commit |-> (vram_pending && !fetch && !$past(mcr_write)))
      else $error("video commit outside a free slot");

endmodule

bind mem_slot_control debug_ram_controller_properties debug_ram_controller_properties_inst
(
   .clk          (clk),
   .reset        (reset),
   .fetch        (fetch),
   .mcr_write    (mcr_write),
   .vram_pending (vram_pending),
   .vram_commit  (vram_commit),
   .dram_ready   (dram_ready),
   .dram_done    (dram_done)
);

// File: bench/debug_ram_controller_tb.sv
// Debug RAM controller testbench
`timescale 1ns/1ps

module debug_ram_controller_tb;

   localparam int mcr_depth  = mem_map_pkg::mcr_depth_default;
   localparam int dram_depth = mem_map_pkg::dram_depth_default;
   localparam int vram_depth = mem_map_pkg::vram_depth_default;
   localparam int word_bits  = mem_map_pkg::mcr_word_bits;
   localparam int data_bits  = mem_map_pkg::data_bits;
   // about 200 operations of up to 12 cycles, doubled
   localparam int timeout_cycles = 5000;

   logic                                   clk;
   logic                                   reset;
   logic                                   fetch;
   mem_bus_pkg::mcr_req_t                  mcr_req;
   mem_bus_pkg::dram_req_t                 dram_req;
   mem_bus_pkg::vram_cpu_req_t             vram_cpu_req;
   logic [mem_map_pkg::vram_addr_bits-1:0] vram_disp_addr;
   logic [word_bits-1:0]                   mcr_rdata;
   logic                                   mcr_done;
   mem_bus_pkg::dram_resp_t                dram_resp;
   mem_bus_pkg::vram_cpu_resp_t            vram_cpu_resp;
   logic [data_bits-1:0]                   vram_disp_rdata;

   // reference memories, all words start at zero
   bit [word_bits-1:0] mcr_ref  [0:mcr_depth-1];
   bit [data_bits-1:0] dram_ref [0:dram_depth-1];
   bit [data_bits-1:0] vram_ref [0:vram_depth-1];

   logic                                   exp_mcr_done;
   logic [word_bits-1:0]                   exp_mcr_rdata;
   int                                     dram_pulse_cycle;
   logic                                   dram_was_write;
   logic                                   ref_pend;
   logic [mem_map_pkg::vram_addr_bits-1:0] ref_pend_addr;
   logic [data_bits-1:0]                   ref_pend_data;
   logic                                   model_commit;
   logic                                   exp_vram_ready;
   logic                                   exp_vram_done;
   int                                     cycles = 0;
   logic [31:0]                            rng_state;
   string                                  test_name;
   logic [mem_map_pkg::mcr_addr_bits-1:0]  mcr_addrs [$];
   logic [mem_map_pkg::dram_addr_bits-1:0] dram_addrs [$];

   tb_clock_gen tb_clock_gen_inst
   (
      .clk   (clk),
      .reset (reset)
   );

   debug_ram_controller #(
      .MCR_DEPTH  (mcr_depth),
      .DRAM_DEPTH (dram_depth),
      .VRAM_DEPTH (vram_depth)
   ) debug_ram_controller_inst
   (
      .clk             (clk),
      .reset           (reset),
      .fetch           (fetch),
      .mcr_req         (mcr_req),
      .dram_req        (dram_req),
      .vram_cpu_req    (vram_cpu_req),
      .vram_disp_addr  (vram_disp_addr),
      .mcr_rdata       (mcr_rdata),
      .mcr_done        (mcr_done),
      .dram_resp       (dram_resp),
      .vram_cpu_resp   (vram_cpu_resp),
      .vram_disp_rdata (vram_disp_rdata)
   );

   // --------------------------------------------------------------------------
   // helpers
   // --------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // main memory word as the range rule sees it
   function automatic logic [data_bits-1:0] dram_expected(
      input logic [mem_map_pkg::dram_addr_bits-1:0] addr);
      if (addr >= dram_depth)
         return '1;
      else
         return dram_ref[addr];
   endfunction

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
      begin
         $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
         $display("Simulation failed");
         $fatal(1, "first mismatch, run stopped");
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic mcr_write_word(input logic [mem_map_pkg::mcr_addr_bits-1:0] addr,
                                 input logic [word_bits-1:0] data);
      mcr_req.addr  = addr;
      mcr_req.wdata = data;
      mcr_req.write = 1'b1;
      next_cycle();
      mcr_req.write = 1'b0;
   endtask

   task automatic mcr_prefetch(input logic [mem_map_pkg::mcr_addr_bits-1:0] addr);
      mcr_req.addr     = addr;
      mcr_req.prefetch = 1'b1;
      next_cycle();
      mcr_req.prefetch = 1'b0;
      next_cycle();
   endtask

   // level held until the ready or done pulse
   task automatic dram_access(input logic [mem_map_pkg::dram_addr_bits-1:0] addr,
                              input logic [data_bits-1:0] data, input logic write);
      dram_req.addr  = addr;
      dram_req.wdata = data;
      dram_req.write = write;
      dram_req.read  = !write;
      do
         @(negedge clk);
      while (!(dram_resp.ready || dram_resp.done));
      next_cycle();
      dram_req.read  = 1'b0;
      dram_req.write = 1'b0;
   endtask

   task automatic vram_write(input logic [mem_map_pkg::vram_addr_bits-1:0] addr,
                             input logic [data_bits-1:0] data);
      vram_cpu_req.addr  = addr;
      vram_cpu_req.wdata = data;
      vram_cpu_req.write = 1'b1;
      next_cycle();
      vram_cpu_req.write = 1'b0;
   endtask

   task automatic wait_vram_done();
      do
         @(negedge clk);
      while (!vram_cpu_resp.done);
      next_cycle();
   endtask

   task automatic vram_read(input logic [mem_map_pkg::vram_addr_bits-1:0] addr);
      vram_cpu_req.addr = addr;
      vram_cpu_req.read = 1'b1;
      next_cycle();
      vram_cpu_req.read = 1'b0;
      do
         @(negedge clk);
      while (!vram_cpu_resp.ready);
      next_cycle();
   endtask

   // --------------------------------------------------------------------------
   // comparing process, mid-cycle when inputs and outputs are settled
   // --------------------------------------------------------------------------
   always @(negedge clk)
   begin
      if (reset)
      begin
         exp_mcr_done     = 1'b0;
         exp_mcr_rdata    = '0;
         dram_pulse_cycle = -1;
         dram_was_write   = 1'b0;
         ref_pend         = 1'b0;
         exp_vram_ready   = 1'b0;
         exp_vram_done    = 1'b0;
      end
      else
      begin
         check_value("mcr_done", exp_mcr_done, mcr_done);
         check_value("mcr_rdata", exp_mcr_rdata, mcr_rdata);
         check_value("dram ready", cycles == dram_pulse_cycle && !dram_was_write,
                     dram_resp.ready);
         check_value("dram done", cycles == dram_pulse_cycle && dram_was_write,
                     dram_resp.done);
         if (dram_resp.ready)
            check_value("dram rdata", dram_expected(dram_req.addr), dram_resp.rdata);
         check_value("vram ready", exp_vram_ready, vram_cpu_resp.ready);
         check_value("vram done", exp_vram_done, vram_cpu_resp.done);
         if (vram_cpu_resp.ready)
            check_value("vram rdata", vram_ref[vram_cpu_req.addr], vram_cpu_resp.rdata);
         check_value("display rdata", vram_ref[vram_disp_addr], vram_disp_rdata);

         // microcode, prefetch sees the word from before a same-edge write
         if (mcr_req.prefetch)
            exp_mcr_rdata = mcr_ref[mcr_req.addr];
         if (mcr_req.write)
            mcr_ref[mcr_req.addr] = mcr_req.wdata;

         // main memory start only with the delay line empty
         if (cycles > dram_pulse_cycle && (dram_req.read || dram_req.write))
         begin
            dram_was_write   = dram_req.write;
            dram_pulse_cycle = cycles + mem_map_pkg::dram_latency;
            if (dram_req.write && dram_req.addr < dram_depth)
               dram_ref[dram_req.addr] = dram_req.wdata;
         end

         // video slot is free outside fetch and microcode write finish
         model_commit = ref_pend && !fetch && !exp_mcr_done;
         if (model_commit)
            vram_ref[ref_pend_addr] = ref_pend_data;
         if (vram_cpu_req.write)
         begin
            ref_pend      = 1'b1;
            ref_pend_addr = vram_cpu_req.addr;
            ref_pend_data = vram_cpu_req.wdata;
         end
         else if (model_commit)
            ref_pend = 1'b0;
         exp_vram_done  = model_commit;
         exp_vram_ready = vram_cpu_req.read;
         exp_mcr_done   = mcr_req.write;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
      begin
         $display("timeout: no response within %0d cycles", timeout_cycles);
         $display("Simulation failed");
         $fatal(1, "run stopped by timeout");
      end
   end

   // --------------------------------------------------------------------------
   // stimulus
   // --------------------------------------------------------------------------
   initial
   begin
      logic [mem_map_pkg::mcr_addr_bits-1:0]  ma;
      logic [mem_map_pkg::dram_addr_bits-1:0] da;
      logic [mem_map_pkg::vram_addr_bits-1:0] va;
      logic [mem_map_pkg::vram_addr_bits-1:0] vb;

      rng_state      = 32'h4b18dbc2;
      fetch          = 1'b0;
      mcr_req        = '0;
      dram_req       = '0;
      vram_cpu_req   = '0;
      vram_disp_addr = '0;
      test_name      = "reset";
      @(negedge reset);
      next_cycle();
      dram_access(22'd100, '0, 1'b0);
      vram_read(15'd100);

      test_name = "mcr_random";
      repeat (24)
      begin
         ma = 14'(next_random() % mcr_depth);
         mcr_addrs.push_back(ma);
         mcr_write_word(ma, 49'({next_random(), next_random()}));
      end
      foreach (mcr_addrs[k])
         mcr_prefetch(mcr_addrs[k]);

      // write and prefetch on one address in the same cycle
      test_name        = "mcr_same_addr";
      mcr_req.addr     = mcr_addrs[0];
      mcr_req.wdata    = 49'({next_random(), next_random()});
      mcr_req.write    = 1'b1;
      mcr_req.prefetch = 1'b1;
      next_cycle();
      mcr_req.write    = 1'b0;
      mcr_req.prefetch = 1'b0;
      next_cycle();
      mcr_prefetch(mcr_addrs[0]);

      test_name = "dram_random";
      repeat (20)
      begin
         da = 22'(next_random() % dram_depth);
         dram_addrs.push_back(da);
         dram_access(da, next_random(), 1'b1);
      end
      foreach (dram_addrs[k])
         dram_access(dram_addrs[k], '0, 1'b0);
      repeat (4)
         dram_access(22'(next_random() % dram_depth), '0, 1'b0);

      // ignored write must not alias into the backed range
      test_name = "dram_range";
      da = 22'(dram_depth + next_random() % 4096);
      dram_access(da, next_random(), 1'b1);
      dram_access(da, '0, 1'b0);
      dram_access(22'(da - dram_depth), '0, 1'b0);
      dram_access(22'h3fffff, '0, 1'b0);

      test_name = "vram_fetch_hold";
      va    = 15'(next_random() % vram_depth);
      fetch = 1'b1;
      vram_write(va, next_random());
      repeat (4)
         next_cycle();
      fetch = 1'b0;
      wait_vram_done();
      vram_disp_addr = va;
      vram_read(va);

      test_name          = "vram_after_mcr";
      va                 = 15'(next_random() % vram_depth);
      mcr_req.addr       = 14'd7;
      mcr_req.wdata      = 49'(next_random());
      mcr_req.write      = 1'b1;
      vram_cpu_req.addr  = va;
      vram_cpu_req.wdata = next_random();
      vram_cpu_req.write = 1'b1;
      next_cycle();
      mcr_req.write      = 1'b0;
      vram_cpu_req.write = 1'b0;
      wait_vram_done();
      vram_disp_addr = va;
      vram_read(va);

      test_name = "vram_replace";
      va    = 15'(next_random() % vram_depth);
      vb    = va ^ 15'd1;
      fetch = 1'b1;
      vram_write(va, next_random());
      vram_write(vb, next_random());
      fetch = 1'b0;
      wait_vram_done();
      vram_disp_addr = vb;
      vram_read(va);
      vram_read(vb);

      test_name = "vram_random";
      repeat (20)
      begin
         va    = 15'(next_random() % vram_depth);
         fetch = (next_random() % 2) == 1;
         vram_write(va, next_random());
         if (fetch)
            repeat (next_random() % 3)
               next_cycle();
         fetch = 1'b0;
         wait_vram_done();
         vram_disp_addr = va;
         vram_read(va);
      end

      test_name = "drain";
      repeat (4)
         next_cycle();
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: filelist.f
rtl/mem_map_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_slot_control.sv
rtl/mcr_ram.sv
rtl/dram_store.sv
rtl/vram_store.sv
rtl/debug_ram_controller.sv
bench/tb_clock_gen.sv
bench/debug_ram_controller_properties.sv
bench/debug_ram_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the debug RAM controller testbench with Verilator
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module debug_ram_controller_tb \
   -f filelist.f --Mdir obj_dir -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Simulation passed$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
